// ==== rtl/dma_defs.svh ====
// Sizes and type codes of the DMA response path, included by the package and every RTL file
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

////////////////////////////////
// Flit format
////////////////////////////////

// Two type bits on top of one content word
`define DMA_FLIT_WIDTH 34
`define DMA_DATA_WIDTH 32

// Flit type codes, bits 33..32
`define DMA_FLIT_PAYLOAD 2'b00
`define DMA_FLIT_HEADER  2'b01
`define DMA_FLIT_LAST    2'b10
`define DMA_FLIT_SINGLE  2'b11

// Packet type codes in the header flit
`define DMA_PKT_L2R_RESP 2'b10
`define DMA_PKT_R2L_RESP 2'b11

////////////////////////////////
// Sizes
////////////////////////////////

// Request table entries and the id that selects one
`define DMA_TABLE_ENTRIES 4
`define DMA_ID_WIDTH      $clog2(`DMA_TABLE_ENTRIES)

// Packet buffer depth in flits, a power of two
`define DMA_BUF_DEPTH 16

// Wishbone burst tags and word step
`define DMA_WB_CTI_INCR  3'b010
`define DMA_WB_CTI_EOB   3'b111
`define DMA_WB_ADDR_STEP 32'd4

`endif

// ==== rtl/dma_pkg.sv ====
// Flit types shared by the buffer, the handler and the testbench; import where a type is used
`include "dma_defs.svh"

package dma_pkg;

  ////////////////////////////////
  // Flit type field
  ////////////////////////////////

  // Position of a flit inside its packet
  typedef enum logic [1:0] {
    PAYLOAD = `DMA_FLIT_PAYLOAD,
    HEADER  = `DMA_FLIT_HEADER,
    LAST    = `DMA_FLIT_LAST,
    SINGLE  = `DMA_FLIT_SINGLE
  } flit_type_e;

  ////////////////////////////////
  // Content word
  ////////////////////////////////

  // Header layout, MSB first
  typedef struct packed {
    // NoC routing, not used on receive
    logic [4:0]                                  dest;
    logic [2:0]                                  pkt_class;
    // L2R or R2L response
    logic [1:0]                                  pkt_type;
    // Marks the final packet of a transfer
    logic                                        resp_last;
    // Request table entry
    logic [`DMA_ID_WIDTH-1:0]                    id;
    logic [`DMA_DATA_WIDTH-11-`DMA_ID_WIDTH-1:0] rsvd;
  } flit_header_t;

  // Header flits decode as fields, all others as one plain word
  typedef union packed {
    flit_header_t               hdr;
    logic [`DMA_DATA_WIDTH-1:0] data;
  } flit_content_u;

  // Full flit as seen on the NoC
  typedef struct packed {
    flit_type_e    ftype;
    flit_content_u content;
  } flit_t;

endpackage

// ==== rtl/flit_stream_if.sv ====
// Buffered flit stream from the packet buffer to the response handler, valid/ready handshake
`timescale 1ns/1ns

interface flit_stream_if;

  // Head flit of the buffer
  dma_pkg::flit_t flit;
  // Head flit present
  logic           valid;
  // Consumer takes the head flit this cycle
  logic           ready;
  // Head flit ends its packet
  logic           last;

  // Buffer side
  modport src (
    output flit, valid, last,
    input  ready
  );

  // Handler side
  modport dst (
    input  flit, valid, last,
    output ready
  );

endinterface

// ==== rtl/dma_packet_buffer.sv ====
// First-word-fall-through flit FIFO between NoC input and response handler, flags packet ends
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_packet_buffer (
  input  logic           clk,
  input  logic           rst,

  // NoC side
  input  dma_pkg::flit_t in_flit_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,

  // Handler side
  flit_stream_if.src     out
);

  import dma_pkg::*;

  localparam int unsigned PTR_W = $clog2(`DMA_BUF_DEPTH);

  ////////////////////////////////
  // Storage and pointers
  ////////////////////////////////

  // Flit slots, no reset needed
  flit_t            mem [`DMA_BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One bit wider than the pointers to tell full from empty
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  // Back-pressure only when every slot is taken
  assign in_ready_o = (count != (PTR_W+1)'(`DMA_BUF_DEPTH));
  assign push       = in_valid_i & in_ready_o;
  assign pop        = out.valid & out.ready;

  ////////////////////////////////
  // Head flit
  ////////////////////////////////

  // Head slot drives the stream directly
  assign out.valid = (count != '0);
  assign out.flit  = mem[rd_ptr];
  // Packet end decided once here
  assign out.last  = (out.flit.ftype == LAST) || (out.flit.ftype == SINGLE);

  // Write port
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/dma_resp_handler.sv ====
// Response decoder: marks L2R completions done and writes R2L data to memory as Wishbone bursts
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_resp_handler (
  input  logic                       clk,
  input  logic                       rst,

  // Buffered flits
  flit_stream_if.dst                 in,

  // Wishbone master, write only
  output logic [`DMA_DATA_WIDTH-1:0] wb_adr_o,
  output logic [`DMA_DATA_WIDTH-1:0] wb_dat_o,
  output logic [3:0]                 wb_sel_o,
  output logic                       wb_we_o,
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic [2:0]                 wb_cti_o,
  output logic [1:0]                 wb_bte_o,
  input  logic                       wb_ack_i,

  // Done event to the done table
  output logic                       done_en_o,
  output logic [`DMA_ID_WIDTH-1:0]   done_pos_o
);

  import dma_pkg::*;

  // FSM states
  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_GET_SIZE = 2'd1;
  localparam logic [1:0] ST_GET_ADDR = 2'd2;
  localparam logic [1:0] ST_DATA     = 2'd3;

  logic [1:0]                 state_q;
  logic [1:0]                 state_d;
  // Write address of the current word
  logic [`DMA_DATA_WIDTH-1:0] addr_q;
  logic [`DMA_DATA_WIDTH-1:0] addr_d;
  // Id and response-last bit from the header
  logic [`DMA_ID_WIDTH-1:0]   id_q;
  logic [`DMA_ID_WIDTH-1:0]   id_d;
  logic                       resp_last_q;
  logic                       resp_last_d;
  // Head flit read as a header
  flit_header_t               hdr;
  // Current word acknowledged
  logic                       word_done;

  assign hdr = in.flit.content.hdr;

  ////////////////////////////////
  // Wishbone outputs
  ////////////////////////////////

  // Full words, linear bursts
  assign wb_sel_o = 4'hf;
  assign wb_bte_o = 2'b00;
  assign wb_adr_o = addr_q;
  // Data word comes straight off the buffer head
  assign wb_dat_o = in.flit.content.data;

  // Strobe only once a data flit sits at the head
  // Head stays put until popped, so adr and dat hold while stb waits
  assign wb_stb_o = (state_q == ST_DATA) & in.valid;
  assign wb_cyc_o = wb_stb_o;
  assign wb_we_o  = wb_stb_o;
  // End of burst on the packet's last flit
  assign wb_cti_o = in.last ? `DMA_WB_CTI_EOB : `DMA_WB_CTI_INCR;

  assign word_done = wb_stb_o & wb_ack_i;

  ////////////////////////////////
  // Next state
  ////////////////////////////////

  always_comb begin
    state_d     = state_q;
    addr_d      = addr_q;
    id_d        = id_q;
    resp_last_d = resp_last_q;
    in.ready    = 1'b0;
    done_en_o   = 1'b0;
    done_pos_o  = id_q;

    case (state_q)
      ST_IDLE: begin
        // Header taken as soon as it shows
        in.ready = 1'b1;
        if (in.valid) begin
          id_d        = hdr.id;
          resp_last_d = hdr.resp_last;
          if (hdr.pkt_type == `DMA_PKT_L2R_RESP) begin
            // Write completion, done right away
            done_en_o  = 1'b1;
            done_pos_o = hdr.id;
          end else if (hdr.pkt_type == `DMA_PKT_R2L_RESP) begin
            state_d = ST_GET_SIZE;
          end
          // Any other type is popped and dropped as a one-flit packet
        end
      end

      ST_GET_SIZE: begin
        // Burst length follows from the last flag, size word is skipped
        in.ready = 1'b1;
        if (in.valid) begin
          state_d = ST_GET_ADDR;
        end
      end

      ST_GET_ADDR: begin
        in.ready = 1'b1;
        if (in.valid) begin
          addr_d  = in.flit.content.data;
          state_d = ST_DATA;
        end
      end

      ST_DATA: begin
        // Pop exactly on the ack
        in.ready = word_done;
        if (word_done) begin
          addr_d = addr_q + `DMA_WB_ADDR_STEP;
          if (in.last) begin
            state_d = ST_IDLE;
            if (resp_last_q) begin
              done_en_o  = 1'b1;
              done_pos_o = id_q;
            end
          end
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // FSM state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Packet fields, loaded before use
  always_ff @(posedge clk) begin
    addr_q      <= addr_d;
    id_q        <= id_d;
    resp_last_q <= resp_last_d;
  end

endmodule

// ==== rtl/dma_done_table.sv ====
// Sticky done bits per request-table entry, cleared by software, with a level interrupt
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_done_table (
  input  logic                         clk,
  input  logic                         rst,

  // Done event from the handler
  input  logic                         done_en_i,
  input  logic [`DMA_ID_WIDTH-1:0]     done_pos_i,

  // Software clear by position
  input  logic                         clear_i,
  input  logic [`DMA_ID_WIDTH-1:0]     clear_pos_i,

  output logic [`DMA_TABLE_ENTRIES-1:0] done_o,
  output logic                         irq_o
);

  ////////////////////////////////
  // Done register
  ////////////////////////////////

  logic [`DMA_TABLE_ENTRIES-1:0] done_q;
  logic [`DMA_TABLE_ENTRIES-1:0] done_d;

  // Clear first, set after it, so set wins on the same entry
  always_comb begin
    done_d = done_q;
    if (clear_i) begin
      done_d[clear_pos_i] = 1'b0;
    end
    if (done_en_i) begin
      done_d[done_pos_i] = 1'b1;
    end
  end

  // irq follows the new bits at the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= '0;
      irq_o  <= 1'b0;
    end else begin
      done_q <= done_d;
      irq_o  <= |done_d;
    end
  end

  assign done_o = done_q;

endmodule

// ==== rtl/dma_resp_top.sv ====
// Response receive path top: packet buffer, response handler and done table behind plain ports
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_resp_top (
  input  logic                          clk,
  input  logic                          rst,

  // NoC response input
  input  logic [`DMA_FLIT_WIDTH-1:0]    noc_in_flit_i,
  input  logic                          noc_in_valid_i,
  output logic                          noc_in_ready_o,

  // Wishbone master to local memory
  output logic [`DMA_DATA_WIDTH-1:0]    wb_adr_o,
  output logic [`DMA_DATA_WIDTH-1:0]    wb_dat_o,
  output logic [3:0]                    wb_sel_o,
  output logic                          wb_we_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic [2:0]                    wb_cti_o,
  output logic [1:0]                    wb_bte_o,
  input  logic                          wb_ack_i,

  // Done status and software clear
  input  logic                          done_clear_i,
  input  logic [`DMA_ID_WIDTH-1:0]      done_clear_pos_i,
  output logic [`DMA_TABLE_ENTRIES-1:0] done_o,
  output logic                          irq_o
);

  ////////////////////////////////
  // Internal links
  ////////////////////////////////

  // Buffer to handler
  flit_stream_if buf_stream ();

  // Handler to done table
  logic                     done_en;
  logic [`DMA_ID_WIDTH-1:0] done_pos;

  dma_packet_buffer dma_packet_buffer_i (
    .clk        (clk),
    .rst        (rst),
    .in_flit_i  (noc_in_flit_i),
    .in_valid_i (noc_in_valid_i),
    .in_ready_o (noc_in_ready_o),
    .out        (buf_stream)
  );

  dma_resp_handler dma_resp_handler_i (
    .clk        (clk),
    .rst        (rst),
    .in         (buf_stream),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_o   (wb_dat_o),
    .wb_sel_o   (wb_sel_o),
    .wb_we_o    (wb_we_o),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_cti_o   (wb_cti_o),
    .wb_bte_o   (wb_bte_o),
    .wb_ack_i   (wb_ack_i),
    .done_en_o  (done_en),
    .done_pos_o (done_pos)
  );

  dma_done_table dma_done_table_i (
    .clk         (clk),
    .rst         (rst),
    .done_en_i   (done_en),
    .done_pos_i  (done_pos),
    .clear_i     (done_clear_i),
    .clear_pos_i (done_clear_pos_i),
    .done_o      (done_o),
    .irq_o       (irq_o)
  );

endmodule

// ==== tests/tb_clkgen.sv ====
// Free-running testbench clock for the DMA response path, 4 ns period
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk_o
);

  // Half period of 2 ns
  initial begin
    clk_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

// ==== tests/dma_resp_sva.sv ====
// Concurrent checks on the NoC and Wishbone handshakes, bound into the response path top
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_resp_sva (
  input logic                          clk,
  input logic                          rst,
  input logic [`DMA_FLIT_WIDTH-1:0]    noc_flit_i,
  input logic                          noc_valid_i,
  input logic                          noc_ready_i,
  input logic                          wb_cyc_i,
  input logic                          wb_stb_i,
  input logic                          wb_ack_i,
  input logic [`DMA_DATA_WIDTH-1:0]    wb_adr_i,
  input logic [`DMA_DATA_WIDTH-1:0]    wb_dat_i,
  input logic [`DMA_TABLE_ENTRIES-1:0] done_i,
  input logic                          irq_i
);

  ////////////////////////////////
  // Wishbone
  ////////////////////////////////

  // Strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_i |-> wb_cyc_i)
    else $error("wb_stb_o high while wb_cyc_o is low");

  // Address and data hold until the word is acknowledged
  wb_hold: assert property (@(posedge clk) disable iff (rst)
    (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_adr_i) && $stable(wb_dat_i)))
    else $error("Wishbone address or data changed while waiting for ack");

  ////////////////////////////////
  // NoC input and status
  ////////////////////////////////

  // A refused flit stays on the input
  noc_hold: assert property (@(posedge clk) disable iff (rst)
    (noc_valid_i && !noc_ready_i) |=> (noc_valid_i && $stable(noc_flit_i)))
    else $error("NoC flit changed or dropped before it was accepted");

  // Interrupt level tracks the done bits
  irq_level: assert property (@(posedge clk) disable iff (rst) irq_i == (|done_i))
    else $error("irq_o does not match the OR of done_o");

endmodule

bind dma_resp_top dma_resp_sva dma_resp_sva_i (
  .clk         (clk),
  .rst         (rst),
  .noc_flit_i  (noc_in_flit_i),
  .noc_valid_i (noc_in_valid_i),
  .noc_ready_i (noc_in_ready_o),
  .wb_cyc_i    (wb_cyc_o),
  .wb_stb_i    (wb_stb_o),
  .wb_ack_i    (wb_ack_i),
  .wb_adr_i    (wb_adr_o),
  .wb_dat_i    (wb_dat_o),
  .done_i      (done_o),
  .irq_i       (irq_o)
);

// ==== tests/dma_resp_tb.sv ====
// Simulation top for the DMA response path that sends packets, models memory and checks results
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_resp_tb;

  import dma_pkg::*;

  // One logged or expected Wishbone write
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [2:0]  cti;
    logic [3:0]  sel;
    logic        we;
    logic [1:0]  bte;
  } wr_rec_t;

  logic                          clk;
  logic                          rst = 1'b1;
  logic [`DMA_FLIT_WIDTH-1:0]    noc_in_flit_i = '0;
  logic                          noc_in_valid_i = 1'b0;
  logic                          noc_in_ready_o;
  logic [31:0]                   wb_adr_o;
  logic [31:0]                   wb_dat_o;
  logic [3:0]                    wb_sel_o;
  logic                          wb_we_o;
  logic                          wb_cyc_o;
  logic                          wb_stb_o;
  logic [2:0]                    wb_cti_o;
  logic [1:0]                    wb_bte_o;
  logic                          wb_ack_i = 1'b0;
  logic                          done_clear_i = 1'b0;
  logic [`DMA_ID_WIDTH-1:0]      done_clear_pos_i = '0;
  logic [`DMA_TABLE_ENTRIES-1:0] done_o;
  logic                          irq_o;

  // Stimulus and scoreboard state
  int                            seed = 32'h34a5;
  flit_t                         tx_q [$];
  wr_rec_t                       wr_log [$];
  wr_rec_t                       exp_q [$];
  logic [`DMA_TABLE_ENTRIES-1:0] exp_done = '0;
  int                            flits_queued = 0;
  int                            flits_accepted = 0;
  int                            n_checks = 0;
  int                            n_errors = 0;
  int                            cycles = 0;
  int                            ack_wait = 0;
  int                            ack_delay = 0;
  logic                          gap_en = 1'b1;
  logic                          slow_ack = 1'b0;
  logic                          saw_full = 1'b0;

  tb_clkgen tb_clkgen_i (
    .clk_o (clk)
  );

  dma_resp_top dma_resp_top_i (
    .clk              (clk),
    .rst              (rst),
    .noc_in_flit_i    (noc_in_flit_i),
    .noc_in_valid_i   (noc_in_valid_i),
    .noc_in_ready_o   (noc_in_ready_o),
    .wb_adr_o         (wb_adr_o),
    .wb_dat_o         (wb_dat_o),
    .wb_sel_o         (wb_sel_o),
    .wb_we_o          (wb_we_o),
    .wb_cyc_o         (wb_cyc_o),
    .wb_stb_o         (wb_stb_o),
    .wb_cti_o         (wb_cti_o),
    .wb_bte_o         (wb_bte_o),
    .wb_ack_i         (wb_ack_i),
    .done_clear_i     (done_clear_i),
    .done_clear_pos_i (done_clear_pos_i),
    .done_o           (done_o),
    .irq_o            (irq_o)
  );

  ////////////////////////////////
  // Reference model
  ////////////////////////////////

  // Expected writes go to exp_q and the returned mask holds the done bits
  function automatic logic [`DMA_TABLE_ENTRIES-1:0] expect_packet(input flit_t pkt[$]);
    flit_header_t                  h;
    wr_rec_t                       w;
    logic [31:0]                   a;
    logic [`DMA_TABLE_ENTRIES-1:0] bits;
    bits = '0;
    h = pkt[0].content.hdr;
    if (h.pkt_type == 2'b10) begin
      // Write completion
      bits[h.id] = 1'b1;
    end else if (h.pkt_type == 2'b11) begin
      // Header, size, address, then one write per data flit
      a = pkt[2].content.data;
      for (int i = 3; i < pkt.size(); i++) begin
        w.adr = a;
        w.dat = pkt[i].content.data;
        // Incrementing burst that ends on the final word
        w.cti = (i == pkt.size() - 1) ? 3'b111 : 3'b010;
        w.sel = 4'hf;
        // Linear write burst
        w.we  = 1'b1;
        w.bte = 2'b00;
        exp_q.push_back(w);
        a = a + 32'd4;
      end
      if (h.resp_last) begin
        bits[h.id] = 1'b1;
      end
    end
    return bits;
  endfunction

  ////////////////////////////////
  // Packet stimulus
  ////////////////////////////////

  // Builds one packet and queues its flits
  task automatic send_packet(input logic [1:0] ptype, input logic [`DMA_ID_WIDTH-1:0] id,
                             input logic rl, input logic [31:0] addr, input int n_words);
    flit_t        pkt [$];
    flit_t        f;
    flit_header_t h;
    h = '0;
    h.dest = 5'd3;
    h.pkt_type = ptype;
    h.resp_last = rl;
    h.id = id;
    f.content.hdr = h;
    if (ptype == `DMA_PKT_R2L_RESP) begin
      f.ftype = HEADER;
      pkt.push_back(f);
      // Size word in bytes
      f.ftype = PAYLOAD;
      f.content.data = 32'(n_words * 4);
      pkt.push_back(f);
      f.content.data = addr;
      pkt.push_back(f);
      for (int i = 0; i < n_words; i++) begin
        f.ftype = (i == n_words - 1) ? LAST : PAYLOAD;
        f.content.data = $random(seed);
        pkt.push_back(f);
      end
    end else begin
      // L2R and unknown types are one flit long
      f.ftype = SINGLE;
      pkt.push_back(f);
    end
    exp_done = exp_done | expect_packet(pkt);
    foreach (pkt[i]) begin
      tx_q.push_back(pkt[i]);
    end
    flits_queued += pkt.size();
  endtask

  // NoC sender holding each flit until accepted with random idle gaps
  always @(posedge clk) begin
    if (rst) begin
      noc_in_valid_i <= 1'b0;
    end else if (!noc_in_valid_i || noc_in_ready_o) begin
      if (noc_in_valid_i) begin
        flits_accepted <= flits_accepted + 1;
      end
      if (tx_q.size() != 0 && !(gap_en && (($random(seed) & 3) == 0))) begin
        noc_in_flit_i  <= tx_q.pop_front();
        noc_in_valid_i <= 1'b1;
      end else begin
        noc_in_valid_i <= 1'b0;
      end
    end
  end

  // Back-pressure seen at least once
  always @(posedge clk) begin
    if (!rst && !noc_in_ready_o) begin
      saw_full <= 1'b1;
    end
  end

  ////////////////////////////////
  // Wishbone memory model
  ////////////////////////////////

  // Acks after 0 to 3 wait cycles and logs each completed word
  always @(posedge clk) begin
    if (rst) begin
      wb_ack_i <= 1'b0;
      ack_wait = 0;
    end else if (wb_stb_o && wb_ack_i) begin
      wr_log.push_back({wb_adr_o, wb_dat_o, wb_cti_o, wb_sel_o, wb_we_o, wb_bte_o});
      wb_ack_i <= 1'b0;
      ack_wait = 0;
      ack_delay = slow_ack ? 3 : ($random(seed) & 3);
    end else if (wb_cyc_o && wb_stb_o) begin
      if (ack_wait >= ack_delay) begin
        wb_ack_i <= 1'b1;
      end else begin
        ack_wait++;
      end
    end
  end

  ////////////////////////////////
  // Checking
  ////////////////////////////////

  // Compares logged writes with the expected list in order
  always @(negedge clk) begin
    wr_rec_t got;
    wr_rec_t want;
    while (wr_log.size() != 0) begin
      got = wr_log.pop_front();
      n_checks++;
      assert (exp_q.size() != 0) else begin
        $display("Unexpected Wishbone write to %h at %0t ns", got.adr, $time);
        n_errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        n_checks += 6;
        assert (got.adr == want.adr) else begin
          $display("Mismatch at %0t ns: wb_adr_o expected %h got %h", $time, want.adr, got.adr);
          n_errors++;
        end
        assert (got.dat == want.dat) else begin
          $display("Mismatch at %0t ns: wb_dat_o expected %h got %h", $time, want.dat, got.dat);
          n_errors++;
        end
        assert (got.cti == want.cti) else begin
          $display("Mismatch at %0t ns: wb_cti_o expected %b got %b", $time, want.cti, got.cti);
          n_errors++;
        end
        assert (got.sel == want.sel) else begin
          $display("Mismatch at %0t ns: wb_sel_o expected %h got %h", $time, want.sel, got.sel);
          n_errors++;
        end
        assert (got.we == want.we) else begin
          $display("Mismatch at %0t ns: wb_we_o expected %b got %b", $time, want.we, got.we);
          n_errors++;
        end
        assert (got.bte == want.bte) else begin
          $display("Mismatch at %0t ns: wb_bte_o expected %b got %b", $time, want.bte, got.bte);
          n_errors++;
        end
      end
    end
  end

  // Done bits and interrupt against the expected set
  task automatic check_done_state();
    n_checks += 2;
    assert (done_o == exp_done) else begin
      $display("Mismatch at %0t ns: done_o expected %b got %b", $time, exp_done, done_o);
      n_errors++;
    end
    assert (irq_o == (|exp_done)) else begin
      $display("Mismatch at %0t ns: irq_o expected %b got %b", $time, |exp_done, irq_o);
      n_errors++;
    end
  endtask

  // Waits until all flits are taken, all writes seen and expected done bits set
  task automatic settle();
    @(posedge clk);
    while (flits_accepted != flits_queued || exp_q.size() != 0 ||
           (done_o & exp_done) != exp_done) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_done_state();
  endtask

  // Software clear of one entry
  task automatic clear_entry(input logic [`DMA_ID_WIDTH-1:0] k);
    @(posedge clk);
    done_clear_i     <= 1'b1;
    done_clear_pos_i <= k;
    @(posedge clk);
    done_clear_i <= 1'b0;
    exp_done[k] = 1'b0;
    @(negedge clk);
    check_done_state();
  endtask

  task automatic print_summary();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
  endtask

  // Run limit of 40 cycles per flit plus 200
  always @(posedge clk) begin
    cycles++;
    if (cycles > 40 * flits_queued + 200) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      print_summary();
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////
  // Test sequence
  ////////////////////////////////

  initial begin
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_done_state();

    // L2R completion without bus traffic
    send_packet(`DMA_PKT_L2R_RESP, 2'd1, 1'b0, 32'h0, 0);
    settle();

    // R2L burst with response-last
    send_packet(`DMA_PKT_R2L_RESP, 2'd2, 1'b1, 32'h0000_1000, 5);
    settle();

    // R2L without response-last followed by an L2R marker
    send_packet(`DMA_PKT_R2L_RESP, 2'd3, 1'b0, 32'h0000_2000, 3);
    send_packet(`DMA_PKT_L2R_RESP, 2'd0, 1'b0, 32'h0, 0);
    settle();
    send_packet(`DMA_PKT_R2L_RESP, 2'd3, 1'b1, 32'h0000_200c, 2);
    settle();

    // Clear single bits until irq drops with the last one
    clear_entry(2'd2);
    clear_entry(2'd0);
    clear_entry(2'd3);
    clear_entry(2'd1);

    // Slow acks and no gaps fill the buffer
    gap_en = 1'b0;
    slow_ack = 1'b1;
    send_packet(`DMA_PKT_R2L_RESP, 2'd2, 1'b1, 32'h0000_4000, 32);
    settle();
    n_checks++;
    assert (saw_full) else begin
      $display("noc_in_ready_o never fell during the long burst");
      n_errors++;
    end
    gap_en = 1'b1;
    slow_ack = 1'b0;

    // Unknown type dropped ahead of a normal packet
    send_packet(2'b01, 2'd0, 1'b1, 32'h0, 0);
    send_packet(`DMA_PKT_R2L_RESP, 2'd1, 1'b1, 32'h0000_3000, 2);
    settle();

    @(posedge clk);
    print_summary();
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/dma_pkg.sv
rtl/flit_stream_if.sv
rtl/dma_packet_buffer.sv
rtl/dma_resp_handler.sv
rtl/dma_done_table.sv
rtl/dma_resp_top.sv
tests/tb_clkgen.sv
tests/dma_resp_sva.sv
tests/dma_resp_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA response path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module dma_resp_tb -f tb.f -o Vdma_resp_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdma_resp_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
fi
exit 1
